/* dv/img_controller_tb.sv */
module img_controller_tb;

    // ==================================================
    // Test constants
    // ==================================================
    localparam int PAT_RAMP          = 0;
    localparam int PAT_INVERT        = 1;
    localparam int PAT_SCRAMBLE      = 2;
    localparam int PAT_STATS         = 3;
    localparam int BLANK_LINE_CYCLES = 20;
    localparam int LINE_GAP_CYCLES   = 4;
    localparam int FRAME_END_CYCLES  = 6;
    localparam int DONE_WAIT_LIMIT   = 400;
    // Thumbnail readout skips whole lines of pixels between kept words
    localparam int WORD_WAIT_LIMIT   = img_pkg::PIXEL_COUNT + 16;
    // 6 tests x 3 frames x 400 cycles, plus 6 readouts x 300 words x 4 cycles
    localparam int TIMEOUT_CYCLES    = 6 * 3 * 400 + 6 * 300 * 4;

    logic               clk;
    logic               arst_n;
    img_pkg::pixel_t    img_d;
    logic               img_fv;
    logic               img_lv;
    logic               capture_start;
    logic               readout_start;
    img_pkg::block_t    ram_block;
    logic               skip_count;
    img_pkg::header_t   header;
    logic               thumb;
    logic               capture_done;
    img_pkg::count_t    pixel_count;
    img_pkg::stat_t     highlight_count;
    img_pkg::stat_t     shadow_count;
    logic               readout_ready;
    logic               readout_trigger;
    img_pkg::word_t     readout_data;

    img_pkg::word_t     model_mem [img_pkg::BLOCK_COUNT][img_pkg::PIXEL_COUNT];
    img_pkg::word_t     expected [$];
    logic [31:0]        rng_state = 32'hef74_97df;
    int                 cycle_count = 0;
    int                 done_count = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 tests_run = 0;
    int                 test_errors_at_start;
    string              test_name;

    img_controller img_controller_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .capture_start   (capture_start),
        .readout_start   (readout_start),
        .ram_block       (ram_block),
        .skip_count      (skip_count),
        .header          (header),
        .thumb           (thumb),
        .capture_done    (capture_done),
        .pixel_count     (pixel_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Count capture_done pulses so a wait cannot miss one
    always @(posedge clk) begin
        if (capture_done) begin
            done_count <= done_count + 1;
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // ==================================================
    // Helpers and reference model
    // ==================================================
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic img_pkg::pixel_t gen_pixel(input int pattern, input int x, input int y);
        int addr;
        addr = y * img_pkg::IMG_WIDTH + x;
        case (pattern)
            PAT_RAMP:     return img_pkg::pixel_t'(addr * 16 + 3);
            PAT_INVERT:   return ~img_pkg::pixel_t'(addr * 16 + 3);
            PAT_SCRAMBLE: return img_pkg::pixel_t'(addr * 97 + 11);
            default: begin
                // Sampled cells cycle bright, dark, mid; the rest are extremes
                if ((x % img_pkg::STAT_GRID == 0) && (y % img_pkg::STAT_GRID == 0)) begin
                    case ((x / 4 + y / 4) % 3)
                        0:       return 12'hfe0 | img_pkg::pixel_t'(x + y);
                        1:       return img_pkg::pixel_t'(x + y);
                        default: return 12'h7c0 + img_pkg::pixel_t'(x);
                    endcase
                end
                return (addr % 2 == 1) ? 12'hfff : 12'h000;
            end
        endcase
    endfunction

    // Sample bits 7..0 in the high byte, bits 11..8 in the low nibble
    function automatic img_pkg::word_t pack_sample(input img_pkg::pixel_t s);
        return {s[7:0], 4'h0, s[11:8]};
    endfunction

    task automatic compare_word(input string what, input img_pkg::word_t exp,
                                input img_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_count(input string what, input img_pkg::count_t exp,
                                 input img_pkg::count_t act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_stat(input string what, input img_pkg::stat_t exp,
                                input img_pkg::stat_t act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    // ==================================================
    // Sensor and capture
    // ==================================================
    task automatic send_frame(input int pattern);
        img_fv = 1'b1;
        repeat (2 * BLANK_LINE_CYCLES) next_cycle();
        for (int y = 0; y < img_pkg::IMG_HEIGHT; y++) begin
            for (int x = 0; x < img_pkg::IMG_WIDTH; x++) begin
                img_lv = 1'b1;
                img_d  = gen_pixel(pattern, x, y);
                next_cycle();
            end
            img_lv = 1'b0;
            img_d  = '0;
            repeat (LINE_GAP_CYCLES) next_cycle();
        end
        img_fv = 1'b0;
        repeat (FRAME_END_CYCLES) next_cycle();
    endtask

    task automatic capture_frame(input img_pkg::block_t blk, input logic skip,
                                 input int skipped_pattern, input int pattern);
        int              done_before;
        int              waited;
        int              exp_high;
        int              exp_shadow;
        img_pkg::pixel_t s;
        img_pkg::addr_t  a;
        done_before   = done_count;
        waited        = 0;
        exp_high      = 0;
        exp_shadow    = 0;
        ram_block     = blk;
        skip_count    = skip;
        capture_start = 1'b1;
        next_cycle();
        capture_start = 1'b0;
        if (skip) begin
            send_frame(skipped_pattern);
        end
        send_frame(pattern);
        while ((done_count == done_before) && (waited < DONE_WAIT_LIMIT)) begin
            next_cycle();
            waited++;
        end
        if (done_count == done_before) begin
            $display("%s: capture_done never pulsed after the frame", test_name);
            errors++;
        end
        for (int y = 0; y < img_pkg::IMG_HEIGHT; y++) begin
            for (int x = 0; x < img_pkg::IMG_WIDTH; x++) begin
                s = gen_pixel(pattern, x, y);
                a = img_pkg::addr_t'(y * img_pkg::IMG_WIDTH + x);
                model_mem[blk][a] = pack_sample(s);
                if ((x % img_pkg::STAT_GRID == 0) && (y % img_pkg::STAT_GRID == 0)) begin
                    if (s[11:5] == 7'h7f) exp_high++;
                    if (s[11:5] == 7'h00) exp_shadow++;
                end
            end
        end
        compare_count("pixel_count", img_pkg::count_t'(img_pkg::PIXEL_COUNT), pixel_count);
        compare_stat("highlight_count", img_pkg::stat_t'(exp_high), highlight_count);
        compare_stat("shadow_count", img_pkg::stat_t'(exp_shadow), shadow_count);
    endtask

    // ==================================================
    // Host stream
    // ==================================================
    task automatic build_expected(input img_pkg::block_t blk, input logic thumb_sel,
                                  input img_pkg::header_t hdr);
        img_pkg::header_t hdr_sr;
        img_pkg::addr_t   a;
        img_pkg::word_t   swapped;
        int               sum_a;
        int               sum_b;
        expected.delete();
        hdr_sr = hdr;
        sum_a  = 0;
        sum_b  = 0;
        for (int i = 0; i < img_pkg::HEADER_WORDS; i++) begin
            expected.push_back(hdr_sr[63:48]);
            hdr_sr = hdr_sr << 16;
        end
        for (int i = 0; i < img_pkg::PIXEL_COUNT; i++) begin
            a = img_pkg::addr_t'(i);
            if (!thumb_sel ||
                (((i % img_pkg::IMG_WIDTH) % img_pkg::THUMB_GRID < img_pkg::THUMB_KEEP) &&
                 ((i / img_pkg::IMG_WIDTH) % img_pkg::THUMB_GRID < img_pkg::THUMB_KEEP))) begin
                expected.push_back(model_mem[blk][a]);
            end
        end
        // Fletcher-32 over byte-swapped words
        foreach (expected[i]) begin
            swapped = {expected[i][7:0], expected[i][15:8]};
            sum_a   = (sum_a + int'(swapped)) % 65535;
            sum_b   = (sum_b + sum_a) % 65535;
        end
        expected.push_back({sum_a[7:0], sum_a[15:8]});
        expected.push_back({sum_b[7:0], sum_b[15:8]});
        for (int i = 0; i < img_pkg::PADDING_WORDS; i++) begin
            expected.push_back('0);
        end
    endtask

    task automatic receive_word(input int gap, output img_pkg::word_t w, output logic ok);
        int waited;
        waited = 0;
        repeat (gap) next_cycle();
        while (!readout_ready && (waited < WORD_WAIT_LIMIT)) begin
            next_cycle();
            waited++;
        end
        ok = readout_ready;
        w  = readout_data;
        if (ok) begin
            readout_trigger = 1'b1;
            next_cycle();
            readout_trigger = 1'b0;
        end
    endtask

    task automatic read_stream(input img_pkg::block_t blk, input logic thumb_sel,
                               input img_pkg::header_t hdr, input logic random_gaps);
        img_pkg::word_t got;
        logic           ok;
        int             gap;
        build_expected(blk, thumb_sel, hdr);
        ram_block     = blk;
        thumb         = thumb_sel;
        header        = hdr;
        readout_start = 1'b1;
        next_cycle();
        readout_start = 1'b0;
        for (int i = 0; i < expected.size(); i++) begin
            gap = 0;
            if (random_gaps) begin
                rng_state = xorshift32(rng_state);
                gap       = int'(rng_state[1:0]);
            end
            receive_word(gap, got, ok);
            if (!ok) begin
                $display("%s: readout_ready stayed low before word %0d", test_name, i);
                errors++;
                break;
            end
            compare_word($sformatf("word %0d", i), expected[i], got);
        end
        repeat (4) next_cycle();
        if (readout_ready) begin
            $display("%s: readout_ready still high after the last padding word", test_name);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name            = name;
        test_errors_at_start = errors;
    endtask

    task automatic finish_test();
        int n;
        n = errors - test_errors_at_start;
        tests_run++;
        $display("%-16s %s (%0d errors)", test_name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic test_full_capture();
        start_test("full_capture");
        compare_count("pixel_count after reset", '0, pixel_count);
        compare_stat("highlight_count after reset", '0, highlight_count);
        compare_stat("shadow_count after reset", '0, shadow_count);
        if (readout_ready || capture_done) begin
            $display("%s: status outputs not low after reset", test_name);
            errors++;
        end
        capture_frame(1'b0, 1'b0, PAT_RAMP, PAT_RAMP);
        read_stream(1'b0, 1'b0, 64'h1a2b_3c4d_5e6f_7081, 1'b0);
        finish_test();
    endtask

    task automatic test_frame_skip();
        start_test("frame_skip");
        capture_frame(1'b1, 1'b1, PAT_SCRAMBLE, PAT_INVERT);
        read_stream(1'b1, 1'b0, 64'hc0de_0002_f00d_beef, 1'b0);
        finish_test();
    endtask

    task automatic test_thumbnail();
        start_test("thumbnail");
        read_stream(1'b0, 1'b1, 64'h7a11_0003_0010_0010, 1'b0);
        finish_test();
    endtask

    task automatic test_statistics();
        start_test("statistics");
        capture_frame(1'b0, 1'b0, PAT_STATS, PAT_STATS);
        finish_test();
    endtask

    task automatic test_back_pressure();
        start_test("back_pressure");
        capture_frame(1'b0, 1'b0, PAT_RAMP, PAT_RAMP);
        read_stream(1'b0, 1'b0, 64'h1a2b_3c4d_5e6f_7081, 1'b1);
        finish_test();
    endtask

    task automatic test_two_blocks();
        start_test("two_blocks");
        capture_frame(1'b0, 1'b0, PAT_INVERT, PAT_INVERT);
        capture_frame(1'b1, 1'b0, PAT_SCRAMBLE, PAT_SCRAMBLE);
        read_stream(1'b0, 1'b0, 64'hb10c_0000_aaaa_5555, 1'b0);
        read_stream(1'b1, 1'b0, 64'hb10c_0001_5555_aaaa, 1'b0);
        finish_test();
    endtask

    initial begin
        arst_n          = 1'b0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        capture_start   = 1'b0;
        readout_start   = 1'b0;
        ram_block       = '0;
        skip_count      = 1'b0;
        header          = '0;
        thumb           = 1'b0;
        readout_trigger = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        next_cycle();

        test_full_capture();
        test_frame_skip();
        test_thumbnail();
        test_statistics();
        test_back_pressure();
        test_two_blocks();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -f vlog.f --top-module img_controller_tb -o img_sim &&
./obj_dir/img_sim 2>&1 | tee sim.log &&
grep -q 'All tests passed!' sim.log &&
echo "Simulation run succeeded" ||
{ echo "Simulation run failed"; exit 1; }

/* src/fletcher_checksum.sv */
module fletcher_checksum (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                clear,
    input  logic                en,
    input  img_pkg::word_t      word,
    output img_pkg::checksum_t  sum
);
    img_pkg::word_t sum_a;
    img_pkg::word_t sum_b;
    img_pkg::word_t swapped;
    img_pkg::word_t next_a;

    // Addition modulo 65535, inputs already reduced
    function automatic img_pkg::word_t add_mod(input img_pkg::word_t x,
                                               input img_pkg::word_t y);
        logic [16:0] total;
        total = {1'b0, x} + {1'b0, y};
        if (total >= 17'd65535) begin
            total = total - 17'd65535;
        end
        return total[15:0];
    endfunction

    // Host treats stream words as little endian
    assign swapped = {word[7:0], word[15:8]};
    assign next_a  = add_mod(sum_a, swapped);
    assign sum     = {sum_b, sum_a};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= next_a;
            sum_b <= add_mod(sum_b, next_a);
        end
    end

endmodule

/* src/frame_rd_if.sv */
// Readout side read port, data one cycle after en
interface frame_rd_if;
    logic            en;
    img_pkg::block_t block;
    img_pkg::addr_t  addr;
    img_pkg::word_t  data;

    modport reader (
        output en,
        output block,
        output addr,
        input  data
    );

    modport store (
        input  en,
        input  block,
        input  addr,
        output data
    );
endinterface

/* src/frame_store.sv */
module frame_store (
    input  logic        clk,
    frame_wr_if.store   wr,
    frame_rd_if.store   rd
);
    // ==================================================
    // Block select is the top address bit
    // ==================================================
    img_pkg::word_t mem [img_pkg::BLOCK_COUNT * img_pkg::PIXEL_COUNT];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[{wr.block, wr.addr}] <= wr.data;
        end
    end

    // Registered read, data holds between reads
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd.data <= mem[{rd.block, rd.addr}];
        end
    end

    // Capture and readout must not touch the same word at once
    a_no_collision: assert property (@(posedge clk)
        !(wr.en && rd.en && (wr.block == rd.block) && (wr.addr == rd.addr)));

endmodule

/* src/frame_wr_if.sv */
// Capture side write port into the frame store
interface frame_wr_if;
    logic            en;
    img_pkg::block_t block;
    img_pkg::addr_t  addr;
    img_pkg::word_t  data;

    modport capture (
        output en,
        output block,
        output addr,
        output data
    );

    modport store (
        input en,
        input block,
        input addr,
        input data
    );
endinterface

/* src/img_controller.sv */
module img_controller (
    input  logic              clk,
    input  logic              arst_n,

    // Sensor port
    input  img_pkg::pixel_t   img_d,
    input  logic              img_fv,
    input  logic              img_lv,

    // Commands, sampled on the start pulses
    input  logic              capture_start,
    input  logic              readout_start,
    input  img_pkg::block_t   ram_block,
    input  logic              skip_count,
    input  img_pkg::header_t  header,
    input  logic              thumb,

    // Capture status
    output logic              capture_done,
    output img_pkg::count_t   pixel_count,
    output img_pkg::stat_t    highlight_count,
    output img_pkg::stat_t    shadow_count,

    // Host stream
    output logic              readout_ready,
    input  logic              readout_trigger,
    output img_pkg::word_t    readout_data
);
    frame_wr_if wr_bus ();
    frame_rd_if rd_bus ();

    // ==================================================
    // Capture -> frame store -> readout
    // ==================================================
    pixel_capture pixel_capture_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .capture_start   (capture_start),
        .skip_count      (skip_count),
        .ram_block       (ram_block),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .wr              (wr_bus.capture),
        .capture_done    (capture_done),
        .pixel_count     (pixel_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    frame_store frame_store_i (
        .clk (clk),
        .wr  (wr_bus.store),
        .rd  (rd_bus.store)
    );

    readout_streamer readout_streamer_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .readout_start   (readout_start),
        .ram_block       (ram_block),
        .thumb           (thumb),
        .header          (header),
        .rd              (rd_bus.reader),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data)
    );

endmodule

/* src/img_pkg.sv */
package img_pkg;

    // ==================================================
    // Image geometry and stream layout
    // ==================================================
    localparam int IMG_WIDTH      = 16;
    localparam int IMG_HEIGHT     = 16;
    localparam int PIXEL_COUNT    = IMG_WIDTH * IMG_HEIGHT;
    localparam int BLOCK_COUNT    = 2;
    localparam int HEADER_WORDS   = 4;
    localparam int CHECKSUM_WORDS = 2;
    localparam int PADDING_WORDS  = 2;

    // Statistics sample every 4th pixel of every 4th line
    localparam int STAT_GRID      = 4;

    // Thumbnail keeps the top-left 2x2 of each 8x8 tile
    localparam int THUMB_GRID     = 8;
    localparam int THUMB_KEEP     = 2;

    // ==================================================
    // Word types
    // ==================================================
    typedef logic [15:0] word_t;
    typedef logic [11:0] pixel_t;
    typedef logic [7:0]  addr_t;
    typedef logic [0:0]  block_t;
    typedef logic [63:0] header_t;
    typedef logic [8:0]  count_t;
    typedef logic [17:0] stat_t;
    // Sum B in the upper half, sum A in the lower half
    typedef logic [31:0] checksum_t;

    // Stored pixel word, sample bytes in little-endian order
    typedef union packed {
        word_t raw;
        struct packed {
            logic [7:0] lo_bits;
            logic [3:0] pad;
            logic [3:0] hi_bits;
        } fields;
    } pixel_word_u;

endpackage

/* src/pixel_capture.sv */
module pixel_capture (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              capture_start,
    input  logic              skip_count,
    input  img_pkg::block_t   ram_block,
    input  img_pkg::pixel_t   img_d,
    input  logic              img_fv,
    input  logic              img_lv,
    frame_wr_if.capture       wr,
    output logic              capture_done,
    output img_pkg::count_t   pixel_count,
    output img_pkg::stat_t    highlight_count,
    output img_pkg::stat_t    shadow_count
);
    enum logic [1:0] {ST_IDLE, ST_WAIT, ST_SKIP, ST_STORE} state;

    img_pkg::pixel_t       d_q;
    logic                  fv_q;
    logic                  lv_q;
    logic                  fv_prev;
    logic                  lv_prev;
    logic                  skip_left;
    img_pkg::block_t       blk;
    logic [$clog2(img_pkg::STAT_GRID)-1:0] pos_x;
    logic [$clog2(img_pkg::STAT_GRID)-1:0] pos_y;
    img_pkg::pixel_word_u  packed_word;
    logic                  frame_start;
    logic                  line_end;
    logic                  stat_sample;

    // Sensor sample register
    always_ff @(posedge clk) begin
        d_q <= img_d;
    end

    assign frame_start = fv_q && !fv_prev;
    assign line_end    = lv_prev && !lv_q;

    always_comb begin
        packed_word.fields.lo_bits = d_q[7:0];
        packed_word.fields.pad     = '0;
        packed_word.fields.hi_bits = d_q[11:8];
    end

    // ==================================================
    // Write port
    // ==================================================
    assign wr.en    = (state == ST_STORE) && lv_q &&
                      (pixel_count != img_pkg::count_t'(img_pkg::PIXEL_COUNT));
    assign wr.block = blk;
    assign wr.addr  = img_pkg::addr_t'(pixel_count);
    assign wr.data  = packed_word.raw;

    // First pixel of the first line in each 4x4 cell
    assign stat_sample = wr.en && (pos_x == '0) && (pos_y == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= ST_IDLE;
            fv_q            <= 1'b0;
            lv_q            <= 1'b0;
            fv_prev         <= 1'b0;
            lv_prev         <= 1'b0;
            skip_left       <= 1'b0;
            blk             <= '0;
            pos_x           <= '0;
            pos_y           <= '0;
            capture_done    <= 1'b0;
            pixel_count     <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            fv_q         <= img_fv;
            lv_q         <= img_lv;
            fv_prev      <= fv_q;
            lv_prev      <= lv_q;
            capture_done <= 1'b0;

            pos_x <= lv_q ? pos_x + 1'b1 : '0;
            if (!fv_q) begin
                pos_y <= '0;
            end else if (line_end) begin
                pos_y <= pos_y + 1'b1;
            end

            if (wr.en) begin
                pixel_count <= pixel_count + 1'b1;
            end
            if (stat_sample && (&d_q[11:5])) begin
                highlight_count <= highlight_count + 1'b1;
            end
            if (stat_sample && !(|d_q[11:5])) begin
                shadow_count <= shadow_count + 1'b1;
            end

            case (state)
                ST_IDLE: begin
                end
                ST_WAIT: begin
                    if (frame_start) begin
                        state <= ST_SKIP;
                    end
                end
                // A skipped frame goes back to waiting for the next one
                ST_SKIP: begin
                    skip_left <= 1'b0;
                    state     <= skip_left ? ST_WAIT : ST_STORE;
                end
                ST_STORE: begin
                    if (!fv_q) begin
                        capture_done <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if (capture_start) begin
                state           <= ST_WAIT;
                skip_left       <= skip_count;
                blk             <= ram_block;
                pixel_count     <= '0;
                highlight_count <= '0;
                shadow_count    <= '0;
            end
        end
    end

    // Address never wraps back to word 0 while a frame is stored
    a_no_wrap: assert property (@(posedge clk) disable iff (!arst_n)
        wr.en |=> !(wr.en && (wr.addr == '0)));

endmodule

/* src/readout_streamer.sv */
module readout_streamer (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              readout_start,
    input  img_pkg::block_t   ram_block,
    input  logic              thumb,
    input  img_pkg::header_t  header,
    frame_rd_if.reader        rd,
    output logic              readout_ready,
    input  logic              readout_trigger,
    output img_pkg::word_t    readout_data
);
    enum logic [2:0] {ST_IDLE, ST_HEADER, ST_PIXELS, ST_CHECKSUM, ST_PADDING} state;

    img_pkg::header_t   header_sr;
    logic [2:0]         shift_cnt;
    img_pkg::block_t    blk;
    logic               thumb_mode;
    img_pkg::count_t    rd_cnt;
    logic               rd_pending;
    logic               rd_more;
    logic [$clog2(img_pkg::IMG_WIDTH)-1:0]  pos_x;
    logic [$clog2(img_pkg::IMG_HEIGHT)-1:0] pos_y;
    logic               load;
    logic               take;
    logic               keep;
    logic               next_valid;
    img_pkg::word_t     next_word;
    logic               cs_en;
    img_pkg::checksum_t cs_sum;

    // ==================================================
    // Checksum over consumed header and pixel words
    // ==================================================
    assign cs_en = readout_ready && readout_trigger &&
                   ((state == ST_HEADER) || (state == ST_PIXELS));

    fletcher_checksum fletcher_checksum_i (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (readout_start),
        .en     (cs_en),
        .word   (readout_data),
        .sum    (cs_sum)
    );

    // Output register is empty or drained this cycle
    assign load = !readout_ready || readout_trigger;
    assign take = rd_pending && load;

    assign keep = !thumb_mode ||
                  (((int'(pos_x) % img_pkg::THUMB_GRID) < img_pkg::THUMB_KEEP) &&
                   ((int'(pos_y) % img_pkg::THUMB_GRID) < img_pkg::THUMB_KEEP));

    // Prefetch the next word only when it has somewhere to go
    assign rd_more  = rd_cnt != img_pkg::count_t'(img_pkg::PIXEL_COUNT);
    assign rd.en    = (state == ST_PIXELS) && rd_more && load;
    assign rd.block = blk;
    assign rd.addr  = img_pkg::addr_t'(rd_cnt);

    always_comb begin
        next_valid = 1'b0;
        next_word  = '0;
        case (state)
            ST_HEADER: begin
                next_valid = 1'b1;
                next_word  = header_sr[63:48];
            end
            ST_PIXELS: begin
                next_valid = take && keep;
                next_word  = rd.data;
            end
            // Word 0 carries sum A, word 1 sum B, low byte first
            ST_CHECKSUM: begin
                next_valid = 1'b1;
                next_word  = shift_cnt[0] ? {cs_sum[23:16], cs_sum[31:24]}
                                          : {cs_sum[7:0], cs_sum[15:8]};
            end
            ST_PADDING: next_valid = 1'b1;
            default: next_valid = 1'b0;
        endcase
    end

    // ==================================================
    // Control state
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= ST_IDLE;
            readout_ready <= 1'b0;
            shift_cnt     <= '0;
            blk           <= '0;
            thumb_mode    <= 1'b0;
            rd_cnt        <= '0;
            rd_pending    <= 1'b0;
            pos_x         <= '0;
            pos_y         <= '0;
        end else begin
            if (load) begin
                readout_ready <= next_valid;
            end
            rd_pending <= rd.en || (rd_pending && !take);
            if (rd.en) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (take) begin
                pos_x <= pos_x + 1'b1;
                if (int'(pos_x) == img_pkg::IMG_WIDTH - 1) begin
                    pos_y <= pos_y + 1'b1;
                end
            end

            case (state)
                ST_IDLE: begin
                    if (readout_start) begin
                        blk        <= ram_block;
                        thumb_mode <= thumb;
                        shift_cnt  <= '0;
                        state      <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (load) begin
                        shift_cnt <= shift_cnt + 1'b1;
                        if (int'(shift_cnt) == img_pkg::HEADER_WORDS - 1) begin
                            shift_cnt <= '0;
                            rd_cnt    <= '0;
                            pos_x     <= '0;
                            pos_y     <= '0;
                            state     <= ST_PIXELS;
                        end
                    end
                end
                // Leave once every word is read, taken and drained
                ST_PIXELS: begin
                    if (load && !rd_more && !rd_pending) begin
                        state <= ST_CHECKSUM;
                    end
                end
                ST_CHECKSUM: begin
                    if (load) begin
                        shift_cnt <= shift_cnt + 1'b1;
                        if (int'(shift_cnt) == img_pkg::CHECKSUM_WORDS - 1) begin
                            state <= ST_PADDING;
                        end
                    end
                end
                ST_PADDING: begin
                    if (load) begin
                        shift_cnt <= shift_cnt + 1'b1;
                        if (int'(shift_cnt) ==
                            img_pkg::CHECKSUM_WORDS + img_pkg::PADDING_WORDS - 1) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Header shifter and output word
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && readout_start) begin
            header_sr <= header;
        end else if ((state == ST_HEADER) && load) begin
            header_sr <= header_sr << 16;
        end
        if (load && next_valid) begin
            readout_data <= next_word;
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        readout_ready && !readout_trigger |=> readout_ready && $stable(readout_data));

endmodule

/* vlog.f */
src/img_pkg.sv
src/frame_wr_if.sv
src/frame_rd_if.sv
src/pixel_capture.sv
src/frame_store.sv
src/fletcher_checksum.sv
src/readout_streamer.sv
src/img_controller.sv
dv/img_controller_tb.sv
